// ==== common/cam_pkg.sv ====
`default_nettype none

package cam_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////////////////////////

    // camera parallel bus
    localparam int d_width        = 8;
    // packed output word
    localparam int wb_width       = 32;
    localparam int bytes_per_word = 4;
    // byte counter inside the packer
    localparam int cnt_width      = $clog2(bytes_per_word);

    // fifo depths
    localparam int sample_depth   = 16;
    localparam int word_depth     = 8;

    localparam int apb_addr_width = 5;

    //////////////////////////////////////////////////////////////////////
    // register map
    //////////////////////////////////////////////////////////////////////

    // bit 0 start, bit 1 irq_en
    localparam logic [apb_addr_width-1:0] reg_ctrl      = 5'h00;
    // bit 0 irq_pending w1c, bit 1 overflow w1c, bit 2 word_avail ro
    localparam logic [apb_addr_width-1:0] reg_status    = 5'h04;
    // read pops one word
    localparam logic [apb_addr_width-1:0] reg_data      = 5'h08;
    // frame starts since reset
    localparam logic [apb_addr_width-1:0] reg_frame_cnt = 5'h0C;

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    // one sensor sample as it sits in the input fifo
    typedef struct packed {
        logic               vsync;
        logic               href;
        logic [d_width-1:0] data;
    } cam_sample_t;

    // apb requester side, no wait states
    typedef struct packed {
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [apb_addr_width-1:0] paddr;
        logic [31:0]               pwdata;
    } apb_req_t;

    typedef enum logic [1:0] {
        cap_idle       = 2'b00,
        cap_wait_frame = 2'b01,
        cap_capture    = 2'b10
    } cap_state_t;

endpackage

`default_nettype wire

// ==== rtl/sync_fifo.sv ====
`default_nettype none

module sync_fifo #(
    parameter int width = 8,
    parameter int depth = 16
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             push,
    input  wire logic [width-1:0] wdata,
    input  wire logic             pop,
    output logic      [width-1:0] rdata,
    output logic                  full,
    output logic                  empty
);

    localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_width = $clog2(depth + 1);

    logic [width-1:0]     mem [depth];
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [cnt_width-1:0] count;

    // accepted operations only
    logic do_push;
    logic do_pop;

    assign full    = (count == cnt_width'(depth));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // first word falls through
    assign rdata = mem[rd_ptr];

    // storage, no reset
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // pointers wrap at depth, which need not be a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop keeps the count
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    a_no_overrun: assert property (@(posedge clk) disable iff (rst)
        count <= cnt_width'(depth))
        else $error("fifo occupancy above depth");

    a_flags_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(full && empty))
        else $error("fifo full and empty together");

endmodule

`default_nettype wire

// ==== capture/capture_fsm.sv ====
`default_nettype none

module capture_fsm (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        start,
    input  wire cam_pkg::cam_sample_t        sample,
    input  wire logic                        empty,
    input  wire logic                        word_full,
    output logic                             pop,
    output logic [cam_pkg::wb_width-1:0]     word,
    output logic                             word_push,
    output logic                             frame_start
);

    import cam_pkg::*;

    cap_state_t           state;
    logic [cnt_width-1:0] byte_cnt;
    // first three bytes of the word, oldest on top
    logic [3*d_width-1:0] shift_q;
    // vsync of the last popped sample
    logic                 prev_vsync;

    logic pixel;
    logic word_done;

    //////////////////////////////////////////////////////////////////////
    // sample handshake
    //////////////////////////////////////////////////////////////////////

    // nothing leaves the input fifo while idle or stalled by the word fifo
    assign pop = (state != cap_idle) && start && !empty && !word_full;

    // pixel bytes count only once a frame has begun
    assign pixel     = pop && (state == cap_capture) && sample.vsync && sample.href;
    assign word_done = pixel && (byte_cnt == cnt_width'(bytes_per_word - 1));

    //////////////////////////////////////////////////////////////////////
    // state, counter, strobes
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= cap_idle;
            byte_cnt    <= '0;
            prev_vsync  <= 1'b1;
            word_push   <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            word_push   <= word_done;
            frame_start <= 1'b0;
            case (state)
                cap_idle: begin
                    byte_cnt   <= '0;
                    // so the first blank sample counts as a frame start
                    prev_vsync <= 1'b1;
                    if (start) begin
                        state <= cap_wait_frame;
                    end
                end
                cap_wait_frame: begin
                    // skip pixels of a frame already running
                    if (!start) begin
                        state <= cap_idle;
                    end else if (pop && !sample.vsync) begin
                        state    <= cap_capture;
                        byte_cnt <= '0;
                    end
                end
                cap_capture: begin
                    if (!start) begin
                        state <= cap_idle;
                    end else if (pop && !sample.vsync) begin
                        // blanking drops a partial word
                        byte_cnt <= '0;
                    end else if (pixel) begin
                        // wraps to zero after the fourth byte
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= cap_idle;
                end
            endcase
            // falling vsync edge seen in the sample stream
            if (pop) begin
                prev_vsync  <= sample.vsync;
                frame_start <= prev_vsync && !sample.vsync;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // byte packer
    //////////////////////////////////////////////////////////////////////

    // first byte ends up in the top bits
    always_ff @(posedge clk) begin
        if (pixel) begin
            shift_q <= {shift_q[2*d_width-1:0], sample.data};
        end
        if (word_done) begin
            word <= {shift_q, sample.data};
        end
    end

    // the full flag is checked at the pop of the fourth byte
    a_push_not_full: assert property (@(posedge clk) disable iff (rst)
        word_push |-> !word_full)
        else $error("word pushed into a full fifo");

    a_pop_not_empty: assert property (@(posedge clk) disable iff (rst)
        pop |-> !empty)
        else $error("sample popped from an empty fifo");

endmodule

`default_nettype wire

// ==== rtl/apb_cam_regs.sv ====
`default_nettype none

module apb_cam_regs (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire cam_pkg::apb_req_t           apb,
    output logic [31:0]                      prdata,
    output logic                             start,
    input  wire logic                        frame_start,
    input  wire logic                        overflow,
    input  wire logic [cam_pkg::wb_width-1:0] word,
    input  wire logic                        word_empty,
    output logic                             word_pop,
    output logic                             irq
);

    import cam_pkg::*;

    logic        irq_en;
    logic        irq_pending;
    logic        overflow_q;
    logic [15:0] frame_cnt;

    // access phase strobes
    logic wr_en;
    logic rd_en;

    assign wr_en = apb.psel && apb.penable && apb.pwrite;
    assign rd_en = apb.psel && apb.penable && !apb.pwrite;

    // data read pops the head word in the same cycle
    assign word_pop = rd_en && (apb.paddr == reg_data) && !word_empty;

    assign irq = irq_pending && irq_en;

    //////////////////////////////////////////////////////////////////////
    // control register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            start  <= 1'b0;
            irq_en <= 1'b0;
        end else if (wr_en && (apb.paddr == reg_ctrl)) begin
            start  <= apb.pwdata[0];
            irq_en <= apb.pwdata[1];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // sticky status and frame counter
    //////////////////////////////////////////////////////////////////////

    // a new event wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            irq_pending <= 1'b0;
            overflow_q  <= 1'b0;
        end else begin
            if (frame_start) begin
                irq_pending <= 1'b1;
            end else if (wr_en && (apb.paddr == reg_status) && apb.pwdata[0]) begin
                irq_pending <= 1'b0;
            end
            if (overflow) begin
                overflow_q <= 1'b1;
            end else if (wr_en && (apb.paddr == reg_status) && apb.pwdata[1]) begin
                overflow_q <= 1'b0;
            end
        end
    end

    // wraps silently at 16 bits
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_cnt <= '0;
        end else if (frame_start) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read mux
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (apb.paddr)
            reg_ctrl:      prdata = {30'b0, irq_en, start};
            reg_status:    prdata = {29'b0, !word_empty, overflow_q, irq_pending};
            // empty fifo reads as zero
            reg_data:      prdata = word_empty ? 32'b0 : word;
            reg_frame_cnt: prdata = {16'b0, frame_cnt};
            default:       prdata = 32'b0;
        endcase
    end

    // access phase always follows a setup phase of the same transfer
    a_apb_phases: assert property (@(posedge clk) disable iff (rst)
        apb.penable |-> apb.psel && $past(apb.psel))
        else $error("apb access phase without setup");

endmodule

`default_nettype wire

// ==== rtl/cam_capture_top.sv ====
`default_nettype none

module cam_capture_top (
    input  wire logic                         clk,
    input  wire logic                         rst,
    // sensor side, strobe synchronous to clk
    input  wire logic                         cam_valid,
    input  wire logic                         cam_vsync,
    input  wire logic                         cam_href,
    input  wire logic [cam_pkg::d_width-1:0]  cam_d,
    // register bus
    input  wire cam_pkg::apb_req_t            apb,
    output logic [31:0]                       prdata,
    output logic                              irq
);

    import cam_pkg::*;

    cam_sample_t         cam_in;
    cam_sample_t         sample_head;
    logic                sample_full;
    logic                sample_empty;
    logic                sample_pop;
    // sample dropped at the input
    logic                overflow;

    logic [wb_width-1:0] word_in;
    logic [wb_width-1:0] word_head;
    logic                word_push;
    logic                word_pop;
    logic                word_full;
    logic                word_empty;

    logic                start;
    logic                frame_start;

    assign cam_in   = '{vsync: cam_vsync, href: cam_href, data: cam_d};
    assign overflow = cam_valid && sample_full;

    //////////////////////////////////////////////////////////////////////
    // sample fifo, no back-pressure toward the sensor
    //////////////////////////////////////////////////////////////////////

    sync_fifo #(
        .width ($bits(cam_sample_t)),
        .depth (sample_depth)
    ) u_sample_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (cam_valid),
        .wdata (cam_in),
        .pop   (sample_pop),
        .rdata (sample_head),
        .full  (sample_full),
        .empty (sample_empty)
    );

    capture_fsm u_capture (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .sample      (sample_head),
        .empty       (sample_empty),
        .word_full   (word_full),
        .pop         (sample_pop),
        .word        (word_in),
        .word_push   (word_push),
        .frame_start (frame_start)
    );

    // packed words waiting for software
    sync_fifo #(
        .width (wb_width),
        .depth (word_depth)
    ) u_word_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (word_push),
        .wdata (word_in),
        .pop   (word_pop),
        .rdata (word_head),
        .full  (word_full),
        .empty (word_empty)
    );

    apb_cam_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .apb         (apb),
        .prdata      (prdata),
        .start       (start),
        .frame_start (frame_start),
        .overflow    (overflow),
        .word        (word_head),
        .word_empty  (word_empty),
        .word_pop    (word_pop),
        .irq         (irq)
    );

endmodule

`default_nettype wire

// ==== bench/cam_tb_tasks.svh ====
`ifndef cam_tb_tasks_svh
`define cam_tb_tasks_svh

//////////////////////////////////////////////////////////////////////
// timing and bookkeeping
//////////////////////////////////////////////////////////////////////

// inputs change a short time after the rising edge
task automatic wait_drive_slot();
    @(posedge clk);
    #10;
endtask

task automatic note_failure(input string msg);
    $display("%s (time %0t)", msg, $time);
    err_cnt++;
endtask

task automatic print_test_result(input int id, input string name, input int errs_before);
    $display("test %0d %s: %0d errors", id, name, err_cnt - errs_before);
endtask

//////////////////////////////////////////////////////////////////////
// typed compares
//////////////////////////////////////////////////////////////////////

task automatic check_word(input string name, input logic [wb_width-1:0] got,
                          input logic [wb_width-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
        $display("ERROR at %0t: %s expected %h got %h", $time, name, exp, got);
        err_cnt++;
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
        $display("ERROR at %0t: %s expected %b got %b", $time, name, exp, got);
        err_cnt++;
    end
endtask

task automatic check_count(input string name, input logic [15:0] got, input logic [15:0] exp);
    check_cnt++;
    if (got !== exp) begin
        $display("ERROR at %0t: %s expected %0d got %0d", $time, name, exp, got);
        err_cnt++;
    end
endtask

//////////////////////////////////////////////////////////////////////
// apb requester, setup then access, no wait states
//////////////////////////////////////////////////////////////////////

task automatic apb_write(input logic [apb_addr_width-1:0] addr, input logic [31:0] data);
    wait_drive_slot();
    apb         = '0;
    apb.psel    = 1'b1;
    apb.pwrite  = 1'b1;
    apb.paddr   = addr;
    apb.pwdata  = data;
    wait_drive_slot();
    apb.penable = 1'b1;
    // register updates on this edge
    wait_drive_slot();
    apb = '0;
endtask

task automatic apb_read(input logic [apb_addr_width-1:0] addr, output logic [31:0] data);
    wait_drive_slot();
    apb         = '0;
    apb.psel    = 1'b1;
    apb.paddr   = addr;
    wait_drive_slot();
    apb.penable = 1'b1;
    // mid access phase, prdata settled
    #40;
    data = prdata;
    wait_drive_slot();
    apb = '0;
endtask

//////////////////////////////////////////////////////////////////////
// pixel source
//////////////////////////////////////////////////////////////////////

// fibonacci lfsr, taps 32 22 2 1, one step per bit
function automatic logic [d_width-1:0] random_byte();
    logic [d_width-1:0] b;
    logic               fb;
    b = '0;
    for (int i = 0; i < d_width; i++) begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        b          = {b[d_width-2:0], fb};
    end
    return b;
endfunction

// vsync low samples, a partial word in the model is lost
task automatic cam_blank(input int n);
    for (int i = 0; i < n; i++) begin
        wait_drive_slot();
        cam_valid = 1'b1;
        cam_vsync = 1'b0;
        cam_href  = 1'b0;
        cam_d     = '0;
    end
    wait_drive_slot();
    cam_valid = 1'b0;
    pix_q.delete();
endtask

// one byte per clock, packed four at a time, first byte on top
task automatic cam_bytes(input int n);
    logic [d_width-1:0] b;
    for (int i = 0; i < n; i++) begin
        b = random_byte();
        wait_drive_slot();
        cam_valid = 1'b1;
        cam_vsync = 1'b1;
        cam_href  = 1'b1;
        cam_d     = b;
        pix_q.push_back(b);
        if (pix_q.size() == bytes_per_word) begin
            exp_q.push_back({pix_q[0], pix_q[1], pix_q[2], pix_q[3]});
            pix_q.delete();
        end
    end
    wait_drive_slot();
    cam_valid = 1'b0;
endtask

`endif

// ==== bench/cam_capture_tb.sv ====
`default_nettype none

module cam_capture_tb;

    import cam_pkg::*;

    // bytes driven per test, sets the run limit
    localparam int bytes_t2       = 16;
    localparam int bytes_t3       = 14;
    localparam int bytes_t4       = 12;
    localparam int bytes_t5       = 120;
    localparam int bytes_t6       = 25;
    localparam int timeout_cycles =
        (bytes_t2 + bytes_t3 + bytes_t4 + bytes_t5 + bytes_t6) * 4 + 2000;

    logic               clk;
    logic               rst;
    logic               cam_valid;
    logic               cam_vsync;
    logic               cam_href;
    logic [d_width-1:0] cam_d;
    apb_req_t           apb;
    logic [31:0]        prdata;
    logic               irq;

    // reference model state
    logic [31:0]         lfsr_state;
    logic [d_width-1:0]  pix_q[$];
    logic [wb_width-1:0] exp_q[$];
    int                  err_cnt;
    int                  check_cnt;
    int                  cycle_cnt;

    `include "cam_tb_tasks.svh"

    cam_capture_top UUT (
        .clk       (clk),
        .rst       (rst),
        .cam_valid (cam_valid),
        .cam_vsync (cam_vsync),
        .cam_href  (cam_href),
        .cam_d     (cam_d),
        .apb       (apb),
        .prdata    (prdata),
        .irq       (irq)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < timeout_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles", cycle_cnt);
        $display("*** FAILED ***");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // word helpers
    //////////////////////////////////////////////////////////////////////

    task automatic wait_word_avail(output logic found);
        logic [31:0] s;
        int          polls;
        found = 1'b0;
        polls = 0;
        while (!found && polls < 64) begin
            apb_read(reg_status, s);
            found = s[2];
            polls++;
        end
        if (!found) note_failure("no word became available");
    endtask

    task automatic read_and_check_word(input string name);
        logic [31:0]         d;
        logic [wb_width-1:0] exp;
        logic                found;
        wait_word_avail(found);
        if (found) begin
            apb_read(reg_data, d);
            if (exp_q.size() == 0) begin
                note_failure("a word was read where none was expected");
            end else begin
                exp = exp_q.pop_front();
                check_word(name, d, exp);
            end
        end
    endtask

    // whatever is left must still follow the model byte order
    task automatic drain_extra_words();
        logic [31:0] s;
        int          n;
        logic        more;
        repeat (40) wait_drive_slot();
        n    = 0;
        more = 1'b1;
        while (more && n < 2 * word_depth) begin
            apb_read(reg_status, s);
            more = s[2];
            if (more) begin
                read_and_check_word("drained word");
            end
            n++;
        end
    endtask

    task automatic check_no_word(input string name);
        logic [31:0] s;
        repeat (10) wait_drive_slot();
        apb_read(reg_status, s);
        check_bit(name, s[2], 1'b0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset_values();
        logic [31:0] rd;
        int          e0;
        e0 = err_cnt;
        check_bit("irq", irq, 1'b0);
        apb_read(reg_ctrl, rd);
        check_word("ctrl", rd, 32'h0);
        apb_read(reg_status, rd);
        check_word("status", rd, 32'h0);
        apb_read(reg_frame_cnt, rd);
        check_word("frame_cnt", rd, 32'h0);
        apb_read(reg_data, rd);
        check_word("data", rd, 32'h0);
        print_test_result(1, "reset values", e0);
    endtask

    task automatic test_four_words();
        int e0;
        e0 = err_cnt;
        apb_write(reg_ctrl, 32'h1);
        cam_blank(2);
        cam_bytes(bytes_t2);
        repeat (4) read_and_check_word("data word");
        check_no_word("status.word_avail");
        print_test_result(2, "four words", e0);
    endtask

    task automatic test_partial_word();
        int e0;
        e0 = err_cnt;
        cam_blank(2);
        cam_bytes(6);
        // bytes 5 and 6 dropped here
        cam_blank(2);
        cam_bytes(8);
        repeat (3) read_and_check_word("data word");
        check_no_word("status.word_avail");
        print_test_result(3, "partial word dropped", e0);
    endtask

    task automatic test_frame_irq();
        logic [31:0] rd;
        logic [15:0] base;
        int          e0;
        int          n;
        e0 = err_cnt;
        // pending left over from earlier frames
        apb_write(reg_status, 32'h1);
        apb_write(reg_ctrl, 32'h3);
        check_bit("irq", irq, 1'b0);
        apb_read(reg_frame_cnt, rd);
        base = rd[15:0];
        for (int k = 1; k <= 2; k++) begin
            cam_bytes(4);
            cam_blank(2);
            n = 0;
            while (irq !== 1'b1 && n < 100) begin
                wait_drive_slot();
                n++;
            end
            check_bit("irq", irq, 1'b1);
            apb_read(reg_frame_cnt, rd);
            check_count("frame_cnt", rd[15:0], base + 16'(k));
            apb_write(reg_status, 32'h1);
            check_bit("irq", irq, 1'b0);
            read_and_check_word("data word");
        end
        // irq masked, pending still set
        apb_write(reg_ctrl, 32'h1);
        cam_bytes(4);
        cam_blank(2);
        rd = '0;
        n  = 0;
        while (!rd[0] && n < 64) begin
            apb_read(reg_status, rd);
            n++;
        end
        check_bit("status.irq_pending", rd[0], 1'b1);
        check_bit("irq", irq, 1'b0);
        apb_read(reg_frame_cnt, rd);
        check_count("frame_cnt", rd[15:0], base + 16'd3);
        read_and_check_word("data word");
        apb_write(reg_status, 32'h1);
        apb_read(reg_status, rd);
        check_bit("status.irq_pending", rd[0], 1'b0);
        print_test_result(4, "frame irq", e0);
    endtask

    task automatic test_backpressure();
        logic [31:0] rd;
        int          e0;
        e0 = err_cnt;
        cam_blank(2);
        cam_bytes(bytes_t5);
        apb_read(reg_status, rd);
        check_bit("status.overflow", rd[1], 1'b1);
        repeat (word_depth) read_and_check_word("data word");
        drain_extra_words();
        apb_write(reg_status, 32'h2);
        apb_read(reg_status, rd);
        check_bit("status.overflow", rd[1], 1'b0);
        // dropped bytes break the model stream
        pix_q.delete();
        exp_q.delete();
        print_test_result(5, "back-pressure and overflow", e0);
    endtask

    task automatic test_start_gate();
        logic [31:0] rd;
        int          e0;
        e0 = err_cnt;
        apb_write(reg_ctrl, 32'h0);
        cam_bytes(sample_depth);
        check_no_word("status.word_avail");
        apb_read(reg_status, rd);
        check_bit("status.overflow", rd[1], 1'b0);
        // input fifo still full, this byte is lost
        cam_bytes(1);
        apb_read(reg_status, rd);
        check_bit("status.overflow", rd[1], 1'b1);
        apb_write(reg_status, 32'h2);
        // bytes ahead of the next frame start are skipped
        pix_q.delete();
        exp_q.delete();
        apb_write(reg_ctrl, 32'h1);
        repeat (30) wait_drive_slot();
        cam_blank(2);
        cam_bytes(8);
        repeat (2) read_and_check_word("data word");
        check_no_word("status.word_avail");
        print_test_result(6, "start gate", e0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        rst        = 1'b1;
        cam_valid  = 1'b0;
        cam_vsync  = 1'b0;
        cam_href   = 1'b0;
        cam_d      = '0;
        apb        = '0;
        lfsr_state = 32'h572c;
        err_cnt    = 0;
        check_cnt  = 0;
        repeat (4) @(posedge clk);
        #10;
        rst = 1'b0;

        test_reset_values();
        test_four_words();
        test_partial_word();
        test_frame_irq();
        test_backpressure();
        test_start_gate();

        $display("6 tests, %0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+bench
common/cam_pkg.sv
rtl/sync_fifo.sv
capture/capture_fsm.sv
rtl/apb_cam_regs.sv
rtl/cam_capture_top.sv
bench/cam_capture_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the camera capture testbench with verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module cam_capture_tb -f compile.f -o cam_sim \
    && ./obj_dir/cam_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "simulation reported failure"; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "no result line in log"; exit 1; }
exit 0
